// File: design/test_ctrl_pkg.sv
// Self-test controller shared definitions
// Packet commands, test numbers, error codes, FSM states and the
// packed structs passed between reader, sequencer and writer
package test_ctrl_pkg;

    // ========================================
    // Protocol encodings
    // ========================================

    // Command field in the top two bits of a header byte
    typedef enum logic [1:0] {
        CMD_TEST_START   = 2'd0,
        CMD_TEST_DATA    = 2'd1,
        CMD_TEST_STOP    = 2'd2,
        CMD_TEST_STOPPED = 2'd3
    } cmd_e;

    typedef enum logic [7:0] {
        TEST_RECEIVE      = 8'd1,
        TEST_SEND         = 8'd2,
        TEST_RECEIVE_SEND = 8'd3
    } test_num_e;

    typedef enum logic [7:0] {
        TEST_ERROR_NONE                  = 8'd0,
        TEST_ERROR_INVALID_START_PAYLOAD = 8'd1,
        TEST_ERROR_INVALID_STOP_PAYLOAD  = 8'd2,
        TEST_ERROR_INVALID_CMD           = 8'd3,
        TEST_ERROR_INVALID_TEST_NUM      = 8'd4,
        TEST_ERROR_INVALID_TEST_DATA     = 8'd5
    } test_err_e;

    // Payload length field of a header byte
    localparam int LEN_W = 6;

    // ========================================
    // Block interfaces
    // ========================================

    // One received byte, tagged with the packet it belongs to
    typedef struct packed {
        logic             is_header;
        cmd_e             cmd;
        logic [LEN_W-1:0] length;
        logic [7:0]       data;
    } rx_evt_t;

    typedef enum logic [1:0] {
        TX_STATUS,
        TX_ECHO,
        TX_STREAM
    } tx_kind_e;

    // One packet for the writer to produce
    typedef struct packed {
        tx_kind_e   kind;
        test_err_e  code;
        logic [1:0] arg_count;
        logic [7:0] arg0;
        logic [7:0] arg1;
        logic [7:0] echo;
    } tx_req_t;

    typedef enum logic [2:0] {
        SEQ_RECEIVE,
        SEQ_ECHO,
        SEQ_STREAM,
        SEQ_REPORT,
        SEQ_DONE
    } seq_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BUFFER,
        WR_HEADER,
        WR_PAYLOAD
    } wr_state_e;

endpackage

// File: design/packet_reader.sv
// Packet reader
// Pulls bytes one at a time from the input FIFO and tags each one as a
// header or as payload of the command that opened the packet. At most
// one byte is in flight, and no read is issued while an event waits.
`timescale 1ns/1ps

module packet_reader (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   empty_i,
    input  logic [7:0]             rd_data_i,
    input  logic                   rx_ready_i,
    output logic                   rd_en_o,
    output test_ctrl_pkg::rx_evt_t rx_evt_o,
    output logic                   rx_valid_o
);

    // Read data is on rd_data_i in the cycle after rd_en_o
    logic                            capture_q;
    test_ctrl_pkg::cmd_e             cur_cmd_q;
    logic [test_ctrl_pkg::LEN_W-1:0] cur_len_q;
    logic [test_ctrl_pkg::LEN_W-1:0] remain_q;

    // ========================================
    // Read, capture, hold
    // ========================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            rd_en_o    <= 1'b0;
            capture_q  <= 1'b0;
            rx_valid_o <= 1'b0;
        end else begin
            rd_en_o   <= !empty_i && !rd_en_o && !capture_q && !rx_valid_o;
            capture_q <= rd_en_o;
            if (capture_q) begin
                rx_valid_o <= 1'b1;
            end else if (rx_valid_o && rx_ready_i) begin
                rx_valid_o <= 1'b0;
            end
        end
    end

    // ========================================
    // Framing
    // ========================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            cur_cmd_q <= test_ctrl_pkg::CMD_TEST_START;
            cur_len_q <= '0;
            remain_q  <= '0;
        end else if (capture_q) begin
            if (remain_q == '0) begin
                // New header, zero length closes the packet at once
                cur_cmd_q <= test_ctrl_pkg::cmd_e'(rd_data_i[7:6]);
                cur_len_q <= rd_data_i[5:0];
                remain_q  <= rd_data_i[5:0];
            end else begin
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    // Event payload, valid while rx_valid_o is high
    always_ff @(posedge clk) begin
        if (capture_q) begin
            rx_evt_o.data <= rd_data_i;
            if (remain_q == '0) begin
                rx_evt_o.is_header <= 1'b1;
                rx_evt_o.cmd       <= test_ctrl_pkg::cmd_e'(rd_data_i[7:6]);
                rx_evt_o.length    <= rd_data_i[5:0];
            end else begin
                rx_evt_o.is_header <= 1'b0;
                rx_evt_o.cmd       <= cur_cmd_q;
                rx_evt_o.length    <= cur_len_q;
            end
        end
    end

endmodule

// File: design/test_sequencer.sv
// Test sequencer
// Runs the self-test protocol on received events: selects the test,
// checks the incrementing data stream, requests echo and stream
// packets, and finishes with one status packet and the outcome flags.
`timescale 1ns/1ps

module test_sequencer (
    input  logic                   clk,
    input  logic                   reset_i,
    input  test_ctrl_pkg::rx_evt_t rx_evt_i,
    input  logic                   rx_valid_i,
    input  logic                   tx_ready_i,
    input  logic                   tx_done_i,
    output logic                   rx_ready_o,
    output test_ctrl_pkg::tx_req_t tx_req_o,
    output logic                   tx_valid_o,
    output logic                   test_ok_o,
    output logic                   test_fail_o
);

    test_ctrl_pkg::seq_state_e state_q;
    test_ctrl_pkg::test_num_e  test_num_q;
    logic [7:0]                expect_q;
    // Request handed to the writer, waiting for tx_done
    logic                      sent_q;

    function automatic test_ctrl_pkg::tx_req_t make_req(
        input test_ctrl_pkg::tx_kind_e  kind,
        input test_ctrl_pkg::test_err_e code,
        input logic [1:0]               arg_count,
        input logic [7:0]               arg0,
        input logic [7:0]               arg1,
        input logic [7:0]               echo
    );
        test_ctrl_pkg::tx_req_t req;
        req.kind      = kind;
        req.code      = code;
        req.arg_count = arg_count;
        req.arg0      = arg0;
        req.arg1      = arg1;
        req.echo      = echo;
        return req;
    endfunction

    // Input is only consumed while receiving
    assign rx_ready_o = (state_q == test_ctrl_pkg::SEQ_RECEIVE);
    assign tx_valid_o = !sent_q && (state_q inside {test_ctrl_pkg::SEQ_ECHO,
                                                    test_ctrl_pkg::SEQ_STREAM,
                                                    test_ctrl_pkg::SEQ_REPORT});

    // ========================================
    // Protocol FSM
    // ========================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q     <= test_ctrl_pkg::SEQ_RECEIVE;
            test_num_q  <= test_ctrl_pkg::TEST_RECEIVE;
            expect_q    <= 8'd0;
            sent_q      <= 1'b0;
            test_ok_o   <= 1'b0;
            test_fail_o <= 1'b0;
        end else begin
            if (tx_valid_o && tx_ready_i) begin
                sent_q <= 1'b1;
            end
            if (tx_done_i) begin
                sent_q <= 1'b0;
            end

            case (state_q)
                test_ctrl_pkg::SEQ_RECEIVE: begin
                    if (rx_valid_i && rx_evt_i.is_header) begin
                        case (rx_evt_i.cmd)
                            test_ctrl_pkg::CMD_TEST_START: begin
                                if (rx_evt_i.length == 6'd1) begin
                                    expect_q <= 8'd0;
                                end else begin
                                    tx_req_o <= make_req(test_ctrl_pkg::TX_STATUS,
                                        test_ctrl_pkg::TEST_ERROR_INVALID_START_PAYLOAD,
                                        2'd0, 8'd0, 8'd0, 8'd0);
                                    state_q <= test_ctrl_pkg::SEQ_REPORT;
                                end
                            end
                            test_ctrl_pkg::CMD_TEST_STOP: begin
                                tx_req_o <= make_req(test_ctrl_pkg::TX_STATUS,
                                    (rx_evt_i.length == '0) ?
                                        test_ctrl_pkg::TEST_ERROR_NONE :
                                        test_ctrl_pkg::TEST_ERROR_INVALID_STOP_PAYLOAD,
                                    2'd0, 8'd0, 8'd0, 8'd0);
                                state_q <= test_ctrl_pkg::SEQ_REPORT;
                            end
                            test_ctrl_pkg::CMD_TEST_STOPPED: begin
                                tx_req_o <= make_req(test_ctrl_pkg::TX_STATUS,
                                    test_ctrl_pkg::TEST_ERROR_INVALID_CMD,
                                    2'd0, 8'd0, 8'd0, 8'd0);
                                state_q <= test_ctrl_pkg::SEQ_REPORT;
                            end
                            // DATA headers only open payload
                            default: begin
                            end
                        endcase
                    end else if (rx_valid_i) begin
                        if (rx_evt_i.cmd == test_ctrl_pkg::CMD_TEST_START) begin
                            case (rx_evt_i.data)
                                test_ctrl_pkg::TEST_RECEIVE,
                                test_ctrl_pkg::TEST_RECEIVE_SEND: begin
                                    test_num_q <= test_ctrl_pkg::test_num_e'(rx_evt_i.data);
                                end
                                test_ctrl_pkg::TEST_SEND: begin
                                    test_num_q <= test_ctrl_pkg::TEST_SEND;
                                    tx_req_o <= make_req(test_ctrl_pkg::TX_STREAM,
                                        test_ctrl_pkg::TEST_ERROR_NONE,
                                        2'd0, 8'd0, 8'd0, 8'd0);
                                    state_q <= test_ctrl_pkg::SEQ_STREAM;
                                end
                                default: begin
                                    tx_req_o <= make_req(test_ctrl_pkg::TX_STATUS,
                                        test_ctrl_pkg::TEST_ERROR_INVALID_TEST_NUM,
                                        2'd1, rx_evt_i.data, 8'd0, 8'd0);
                                    state_q <= test_ctrl_pkg::SEQ_REPORT;
                                end
                            endcase
                        end else if (rx_evt_i.cmd == test_ctrl_pkg::CMD_TEST_DATA) begin
                            if (rx_evt_i.data == expect_q) begin
                                expect_q <= expect_q + 8'd1;
                                if (test_num_q == test_ctrl_pkg::TEST_RECEIVE_SEND) begin
                                    tx_req_o <= make_req(test_ctrl_pkg::TX_ECHO,
                                        test_ctrl_pkg::TEST_ERROR_NONE,
                                        2'd0, 8'd0, 8'd0, rx_evt_i.data);
                                    state_q <= test_ctrl_pkg::SEQ_ECHO;
                                end
                            end else begin
                                // Arguments are actual then expected
                                tx_req_o <= make_req(test_ctrl_pkg::TX_STATUS,
                                    test_ctrl_pkg::TEST_ERROR_INVALID_TEST_DATA,
                                    2'd2, rx_evt_i.data, expect_q, 8'd0);
                                state_q <= test_ctrl_pkg::SEQ_REPORT;
                            end
                        end
                    end
                end

                test_ctrl_pkg::SEQ_ECHO: begin
                    if (tx_done_i) begin
                        state_q <= test_ctrl_pkg::SEQ_RECEIVE;
                    end
                end

                test_ctrl_pkg::SEQ_STREAM: begin
                    if (tx_done_i) begin
                        tx_req_o <= make_req(test_ctrl_pkg::TX_STATUS,
                            test_ctrl_pkg::TEST_ERROR_NONE, 2'd0, 8'd0, 8'd0, 8'd0);
                        state_q <= test_ctrl_pkg::SEQ_REPORT;
                    end
                end

                test_ctrl_pkg::SEQ_REPORT: begin
                    if (tx_done_i) begin
                        test_ok_o   <= (tx_req_o.code == test_ctrl_pkg::TEST_ERROR_NONE);
                        test_fail_o <= (tx_req_o.code != test_ctrl_pkg::TEST_ERROR_NONE);
                        state_q     <= test_ctrl_pkg::SEQ_DONE;
                    end
                end

                // Idle until reset
                default: begin
                end
            endcase
        end
    end

endmodule

// File: design/packet_writer.sv
// Packet writer
// Serializes status and echo packets from a small byte buffer, and
// generates framed streams of incrementing data. Writes one byte per
// cycle while the output FIFO is neither full nor almost full.
`timescale 1ns/1ps

module packet_writer #(
    parameter int SEND_LEN     = 4,
    parameter int SEND_PACKETS = 2
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  test_ctrl_pkg::tx_req_t tx_req_i,
    input  logic                   tx_valid_i,
    input  logic                   full_i,
    input  logic                   afull_i,
    output logic                   tx_ready_o,
    output logic                   tx_done_o,
    output logic                   wr_en_o,
    output logic [7:0]             wr_data_o
);

    test_ctrl_pkg::wr_state_e        state_q;
    logic [7:0]                      pkt_buf [4];
    logic [1:0]                      idx_q;
    logic [1:0]                      last_idx_q;
    logic [test_ctrl_pkg::LEN_W-1:0] pay_left_q;
    logic [7:0]                      pkt_left_q;
    logic [7:0]                      data_q;
    logic                            can_wr;
    logic                            last_byte;

    assign can_wr     = !full_i && !afull_i;
    assign tx_ready_o = (state_q == test_ctrl_pkg::WR_IDLE);
    assign wr_en_o    = can_wr && (state_q != test_ctrl_pkg::WR_IDLE);

    // Last byte of the current request
    assign last_byte = (state_q == test_ctrl_pkg::WR_BUFFER && idx_q == last_idx_q) ||
                       (state_q == test_ctrl_pkg::WR_PAYLOAD && pay_left_q == 6'd1 &&
                        pkt_left_q == 8'd1);
    assign tx_done_o = wr_en_o && last_byte;

    always_comb begin
        case (state_q)
            test_ctrl_pkg::WR_BUFFER:  wr_data_o = pkt_buf[idx_q];
            test_ctrl_pkg::WR_HEADER:  wr_data_o = {test_ctrl_pkg::CMD_TEST_DATA,
                                                    test_ctrl_pkg::LEN_W'(SEND_LEN)};
            test_ctrl_pkg::WR_PAYLOAD: wr_data_o = data_q;
            default:                   wr_data_o = 8'h00;
        endcase
    end

    // Status and echo bytes, loaded when a request is taken
    always_ff @(posedge clk) begin
        if (tx_valid_i && tx_ready_o) begin
            if (tx_req_i.kind == test_ctrl_pkg::TX_ECHO) begin
                pkt_buf[0] <= {test_ctrl_pkg::CMD_TEST_DATA, 6'd1};
                pkt_buf[1] <= tx_req_i.echo;
            end else begin
                pkt_buf[0] <= {test_ctrl_pkg::CMD_TEST_STOPPED, 4'd0, tx_req_i.arg_count + 2'd1};
                pkt_buf[1] <= tx_req_i.code;
                pkt_buf[2] <= tx_req_i.arg0;
                pkt_buf[3] <= tx_req_i.arg1;
            end
        end
    end

    // ========================================
    // Writer FSM
    // ========================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q    <= test_ctrl_pkg::WR_IDLE;
            idx_q      <= 2'd0;
            last_idx_q <= 2'd0;
            pay_left_q <= '0;
            pkt_left_q <= 8'd0;
            data_q     <= 8'd0;
        end else begin
            case (state_q)
                test_ctrl_pkg::WR_IDLE: begin
                    if (tx_valid_i) begin
                        idx_q <= 2'd0;
                        case (tx_req_i.kind)
                            test_ctrl_pkg::TX_STREAM: begin
                                pkt_left_q <= 8'(SEND_PACKETS);
                                data_q     <= 8'd0;
                                state_q    <= test_ctrl_pkg::WR_HEADER;
                            end
                            test_ctrl_pkg::TX_ECHO: begin
                                last_idx_q <= 2'd1;
                                state_q    <= test_ctrl_pkg::WR_BUFFER;
                            end
                            default: begin
                                last_idx_q <= tx_req_i.arg_count + 2'd1;
                                state_q    <= test_ctrl_pkg::WR_BUFFER;
                            end
                        endcase
                    end
                end

                test_ctrl_pkg::WR_BUFFER: begin
                    if (can_wr) begin
                        idx_q <= idx_q + 2'd1;
                        if (last_byte) begin
                            state_q <= test_ctrl_pkg::WR_IDLE;
                        end
                    end
                end

                test_ctrl_pkg::WR_HEADER: begin
                    if (can_wr) begin
                        pay_left_q <= test_ctrl_pkg::LEN_W'(SEND_LEN);
                        state_q    <= test_ctrl_pkg::WR_PAYLOAD;
                    end
                end

                default: begin
                    if (can_wr) begin
                        data_q     <= data_q + 8'd1;
                        pay_left_q <= pay_left_q - 1'b1;
                        if (pay_left_q == 6'd1) begin
                            pkt_left_q <= pkt_left_q - 8'd1;
                            state_q    <= (pkt_left_q == 8'd1) ? test_ctrl_pkg::WR_IDLE :
                                                                 test_ctrl_pkg::WR_HEADER;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: design/test_ctrl_top.sv
// FIFO-fed self-test controller
// Reads framed command packets from an input byte FIFO, runs the
// receive, send or loopback test and writes response packets to an
// output byte FIFO. test_ok_o or test_fail_o reports the outcome.
`timescale 1ns/1ps

module test_ctrl_top #(
    parameter int SEND_LEN     = 4,
    parameter int SEND_PACKETS = 2
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       rd_empty_i,
    input  logic [7:0] rd_data_i,
    input  logic       full_i,
    input  logic       afull_i,
    output logic       rd_en_o,
    output logic       wr_en_o,
    output logic [7:0] wr_data_o,
    output logic       test_ok_o,
    output logic       test_fail_o
);

    test_ctrl_pkg::rx_evt_t rx_evt;
    logic                   rx_valid;
    logic                   rx_ready;
    test_ctrl_pkg::tx_req_t tx_req;
    logic                   tx_valid;
    logic                   tx_ready;
    logic                   tx_done;

    packet_reader reader0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .empty_i    (rd_empty_i),
        .rd_data_i  (rd_data_i),
        .rx_ready_i (rx_ready),
        .rd_en_o    (rd_en_o),
        .rx_evt_o   (rx_evt),
        .rx_valid_o (rx_valid)
    );

    test_sequencer seq0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .rx_evt_i    (rx_evt),
        .rx_valid_i  (rx_valid),
        .tx_ready_i  (tx_ready),
        .tx_done_i   (tx_done),
        .rx_ready_o  (rx_ready),
        .tx_req_o    (tx_req),
        .tx_valid_o  (tx_valid),
        .test_ok_o   (test_ok_o),
        .test_fail_o (test_fail_o)
    );

    packet_writer #(
        .SEND_LEN     (SEND_LEN),
        .SEND_PACKETS (SEND_PACKETS)
    ) writer0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .tx_req_i   (tx_req),
        .tx_valid_i (tx_valid),
        .full_i     (full_i),
        .afull_i    (afull_i),
        .tx_ready_o (tx_ready),
        .tx_done_o  (tx_done),
        .wr_en_o    (wr_en_o),
        .wr_data_o  (wr_data_o)
    );

endmodule

// File: sim/test_ctrl_assertions.sv
// Self-test controller assertions
// FIFO handshake rules and outcome flag checks, bound to the top level
`timescale 1ns/1ps

module test_ctrl_assertions (
    input logic clk,
    input logic reset_i,
    input logic full_i,
    input logic afull_i,
    input logic rd_en_i,
    input logic wr_en_i,
    input logic test_ok_i,
    input logic test_fail_i
);

    // Output FIFO back-pressure
    no_write_when_full: assert property (@(posedge clk) disable iff (reset_i)
        (full_i || afull_i) |-> !wr_en_i)
        else $error("wr_en_o high while the output FIFO is full or almost full");

    // One read per byte, never back to back
    single_read: assert property (@(posedge clk) disable iff (reset_i)
        rd_en_i |=> !rd_en_i)
        else $error("rd_en_o high on two consecutive cycles");

    one_outcome: assert property (@(posedge clk) disable iff (reset_i)
        !(test_ok_i && test_fail_i))
        else $error("test_ok_o and test_fail_o high together");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |-> (!test_ok_i && !test_fail_i && !rd_en_i && !wr_en_i))
        else $error("Outputs not low after reset");

endmodule

bind test_ctrl_top test_ctrl_assertions asrt0 (
    .clk         (clk),
    .reset_i     (reset_i),
    .full_i      (full_i),
    .afull_i     (afull_i),
    .rd_en_i     (rd_en_o),
    .wr_en_i     (wr_en_o),
    .test_ok_i   (test_ok_o),
    .test_fail_i (test_fail_o)
);

// File: sim/test_ctrl_checker.sv
// Self-test controller output checker
// Compares every output FIFO write with the expected bytes of the
// current test, and the outcome flags when the test ends. Also watches
// that no input FIFO read happens once the test has ended
`timescale 1ns/1ps

module test_ctrl_checker #(
    parameter int MAX_BYTES = 64
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       rd_en_i,
    input  logic       wr_en_i,
    input  logic [7:0] wr_data_i,
    input  logic       test_ok_i,
    input  logic       test_fail_i,
    input  logic [7:0] exp_bytes_i [MAX_BYTES],
    input  logic [7:0] exp_count_i,
    input  logic       exp_ok_i,
    output int         errors_o
);

    localparam int IDX_W = $clog2(MAX_BYTES);

    int   wr_idx;
    logic outcome_seen;
    int   err_count = 0;

    assign errors_o = err_count;

    // Sampled half a cycle after the DUT updates
    always @(negedge clk) begin
        int new_errs;
        new_errs = 0;
        if (reset_i) begin
            wr_idx       <= 0;
            outcome_seen <= 1'b0;
        end else begin
            if (wr_en_i) begin
                if (wr_idx >= int'(exp_count_i)) begin
                    $display("Extra byte 0x%02h written after the last expected byte",
                             wr_data_i);
                    new_errs++;
                end else if (wr_data_i !== exp_bytes_i[wr_idx[IDX_W-1:0]]) begin
                    $display("error: wr_data_o byte %0d expected 0x%02h got 0x%02h",
                             wr_idx, exp_bytes_i[wr_idx[IDX_W-1:0]], wr_data_i);
                    new_errs++;
                end
                wr_idx <= wr_idx + 1;
            end
            // Status packet is complete once a flag rises
            if ((test_ok_i || test_fail_i) && !outcome_seen) begin
                outcome_seen <= 1'b1;
                if (wr_idx < int'(exp_count_i)) begin
                    $display("Output ended after %0d of %0d expected bytes",
                             wr_idx, exp_count_i);
                    new_errs++;
                end
                if (test_ok_i != exp_ok_i || test_fail_i == exp_ok_i) begin
                    $display("Wrong outcome, test_ok_o is %0b and test_fail_o is %0b",
                             test_ok_i, test_fail_i);
                    new_errs++;
                end
            end
            // A finished test leaves the input FIFO alone
            if ((test_ok_i || test_fail_i) && rd_en_i) begin
                $display("Input FIFO read after the test ended");
                new_errs++;
            end
        end
        err_count <= err_count + new_errs;
    end

endmodule

// File: sim/tb_test_ctrl.sv
// Testbench for the FIFO-fed self-test controller
// Reads per-test stimulus and expected responses from the vectors file,
// feeds a one-cycle-latency input FIFO model and reports each test
`timescale 1ns/1ps

module tb_test_ctrl;

    localparam int EXP_AW         = 6;
    localparam int MAX_BYTES      = 1 << EXP_AW;
    localparam int VEC_AW         = 8;
    localparam int VEC_WORDS      = 1 << VEC_AW;
    localparam int TIMEOUT_CYCLES = 1000;
    localparam int SETTLE_CYCLES  = 8;

    logic       clk;
    logic       reset_i    = 1'b1;
    logic       rd_empty_i = 1'b1;
    logic [7:0] rd_data_i  = 8'h00;
    logic       full_i     = 1'b0;
    logic       afull_i    = 1'b0;
    logic       rd_en_o;
    logic       wr_en_o;
    logic [7:0] wr_data_o;
    logic       test_ok_o;
    logic       test_fail_o;

    // Test control, changed only at the falling edge
    logic       reset_req    = 1'b1;
    logic       backpressure = 1'b0;
    logic [7:0] in_fifo [$];
    logic [7:0] vec_mem [VEC_WORDS];
    logic [7:0] exp_bytes [MAX_BYTES];
    logic [7:0] exp_count    = 8'd0;
    logic       exp_ok       = 1'b1;
    int         errors;

    test_ctrl_top dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_empty_i  (rd_empty_i),
        .rd_data_i   (rd_data_i),
        .full_i      (full_i),
        .afull_i     (afull_i),
        .rd_en_o     (rd_en_o),
        .wr_en_o     (wr_en_o),
        .wr_data_o   (wr_data_o),
        .test_ok_o   (test_ok_o),
        .test_fail_o (test_fail_o)
    );

    test_ctrl_checker #(
        .MAX_BYTES (MAX_BYTES)
    ) chk0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_en_i     (rd_en_o),
        .wr_en_i     (wr_en_o),
        .wr_data_i   (wr_data_o),
        .test_ok_i   (test_ok_o),
        .test_fail_i (test_fail_o),
        .exp_bytes_i (exp_bytes),
        .exp_count_i (exp_count),
        .exp_ok_i    (exp_ok),
        .errors_o    (errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // DUT input drivers and FIFO model
    // ========================================
    always @(posedge clk) begin
        reset_i <= reset_req;
        full_i  <= 1'b0;
        afull_i <= backpressure && (($urandom % 3) == 0);
    end

    // Data appears the cycle after rd_en_o
    always @(posedge clk) begin
        if (rd_en_o && in_fifo.size() != 0) begin
            rd_data_i <= in_fifo.pop_front();
        end
        rd_empty_i <= (in_fifo.size() == 0);
    end

    function automatic logic [7:0] vec_at(input int pos);
        return vec_mem[pos[VEC_AW-1:0]];
    endfunction

    task automatic load_test(input int base, input int n_in, input int n_out);
        int i;
        in_fifo.delete();
        for (i = 0; i < n_in; i++) begin
            in_fifo.push_back(vec_at(base + i));
        end
        for (i = 0; i < n_out; i++) begin
            exp_bytes[i[EXP_AW-1:0]] = vec_at(base + n_in + i);
        end
    endtask

    task automatic wait_for_outcome(output logic timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        while (!test_ok_o && !test_fail_o && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
            end
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int   ptr;
        int   n_in;
        int   n_out;
        int   n_tests;
        int   n_failed;
        int   errs_before;
        logic timed_out;

        void'($urandom(24));
        $readmemh("sim/test_ctrl_vectors.txt", vec_mem);
        ptr      = 0;
        n_tests  = 0;
        n_failed = 0;

        while (ptr + 4 <= VEC_WORDS && vec_at(ptr) != 8'h00) begin
            n_in  = int'(vec_at(ptr));
            n_out = int'(vec_at(ptr + 1));
            n_tests++;

            // DUT idles after each test, so every test starts from reset
            @(negedge clk);
            reset_req = 1'b1;
            @(negedge clk);
            load_test(ptr + 4, n_in, n_out);
            exp_count    = vec_at(ptr + 1);
            exp_ok       = (vec_at(ptr + 2) == 8'h01);
            backpressure = (vec_at(ptr + 3) != 8'h00);
            @(negedge clk);
            reset_req = 1'b0;

            errs_before = errors;
            wait_for_outcome(timed_out);
            if (timed_out) begin
                $display("test %0d: no outcome flag within %0d cycles", n_tests,
                         TIMEOUT_CYCLES);
            end else begin
                // Window for stray writes after the status packet
                repeat (SETTLE_CYCLES) @(negedge clk);
            end
            if (timed_out || errors != errs_before) begin
                n_failed++;
                $display("test %0d: FAILED", n_tests);
            end else begin
                $display("test %0d: ok", n_tests);
            end
            ptr = ptr + 4 + n_in + n_out;
        end

        // Checker counts land one falling edge later
        @(negedge clk);
        $display("%0d tests run, %0d passed, %0d failed", n_tests, n_tests - n_failed,
                 n_failed);
        if (n_failed == 0 && errors == 0 && n_tests > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim/test_ctrl_vectors.txt
// Per test: n_in n_out outcome backpressure (outcome 01 ok, 02 fail)
// then n_in input bytes, then n_out expected output bytes; 00 ends the list
// Receive test 1, data 0..2, STOP
07 02 01 00
01 01 43 00 01 02 80
c1 00
// Loopback test 3, data 0..3, STOP
08 0a 01 00
01 03 44 00 01 02 03 80
41 00 41 01 41 02 41 03 c1 00
// Send test 2 under random almost-full
02 0c 01 01
01 02
44 00 01 02 03 44 04 05 06 07 c1 00
// Bad data byte 5 where 2 is expected
06 04 02 00
01 01 43 00 01 05
c3 05 05 02
// START of length 2
03 02 02 00
02 01 01
c1 01
// Unknown test number 9
02 03 02 00
01 09
c2 04 09
// STOP of length 1
04 02 02 00
01 01 81 00
c1 02
// STOPPED header from the host
01 02 02 00
c0
c1 03
00

// File: sim.f
design/test_ctrl_pkg.sv
design/packet_reader.sv
design/test_sequencer.sv
design/packet_writer.sv
design/test_ctrl_top.sv
sim/test_ctrl_assertions.sv
sim/test_ctrl_checker.sv
sim/tb_test_ctrl.sv

// File: Makefile
# Verilator build and run for the self-test controller testbench

TOP := tb_test_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir
